// ==== rtl/burstCounter.sv ====
// ####################################################################
// Burst counter, nibble-loadable 8-bit down counter
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module burstCounter (
  input  logic                               CLK,
  input  logic                               reset,
  input  clkDiagPkg::ldPulse_t               ldPulse,
  input  clkDiagPkg::loadData_u              loadData,
  input  logic                               burstRun,
  output logic [clkCtlPkg::BURST_W-1:0]      count,
  output logic                               countZero
);
  import clkCtlPkg::*;

  // Terminal count seen by run control and by the decrement
  assign countZero = (count == '0);

  always_ff @(posedge CLK) begin
    if (reset) begin
      count <= '0;
    end else if (ldPulse.burstLo || ldPulse.burstHi) begin
      // Nibble loads take priority over counting
      if (ldPulse.burstLo) begin
        count[3:0] <= loadData.nibble;
      end
      if (ldPulse.burstHi) begin
        count[BURST_W-1:4] <= loadData.nibble;
      end
    end else if (burstRun && !countZero) begin
      // One count per enabled burst cycle
      count <= count - BURST_W'(1);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/clkBoard.sv ====
// ####################################################################
// Clock board diagnostic control, top level
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module clkBoard (
  input  logic                   CLK,
  input  logic                   reset,
  input  clkDiagPkg::diagBus_t   diagBus,
  input  clkCtlPkg::parityIn_t   parity,
  output clkCtlPkg::eboxClkEn_t  eboxClkEn,
  output logic                   mrReset,
  output logic                   errorStop,
  output logic                   ebusDriving,
  output clkDiagPkg::readWord_t  ebusData
);
  import clkDiagPkg::*;
  import clkCtlPkg::*;

  ctlPulse_t          ctlPulse;
  ldPulse_t           ldPulse;
  loadData_u          loadData;
  clkConfig_t         cfg;
  runState_t          runState;
  errFlags_t          errFlags;
  logic [BURST_W-1:0] count;
  logic               countZero;

  // Data nibble shared by all load functions
  assign loadData.nibble = diagBus.data;

  assign mrReset   = runState.mrReset;
  assign errorStop = errFlags.errorStop;

  diagFuncDecoder i_diagFuncDecoder (
    .diagBus  (diagBus),
    .ctlPulse (ctlPulse),
    .ldPulse  (ldPulse)
  );

  clkConfigRegs i_clkConfigRegs (
    .CLK      (CLK),
    .reset    (reset),
    .ldPulse  (ldPulse),
    .loadData (loadData),
    .cfg      (cfg)
  );

  burstCounter i_burstCounter (
    .CLK       (CLK),
    .reset     (reset),
    .ldPulse   (ldPulse),
    .loadData  (loadData),
    .burstRun  (runState.burst),
    .count     (count),
    .countZero (countZero)
  );

  runControl i_runControl (
    .CLK       (CLK),
    .reset     (reset),
    .ctlPulse  (ctlPulse),
    .cfg       (cfg),
    .countZero (countZero),
    .errorStop (errFlags.errorStop),
    .runState  (runState),
    .eboxClkEn (eboxClkEn)
  );

  // Errors clear on the clear reset function
  errorCapture i_errorCapture (
    .CLK      (CLK),
    .reset    (reset),
    .parity   (parity),
    .cfg      (cfg),
    .clrErr   (ctlPulse.clrReset),
    .errFlags (errFlags)
  );

  diagReadback i_diagReadback (
    .diagBus     (diagBus),
    .cfg         (cfg),
    .runState    (runState),
    .errFlags    (errFlags),
    .count       (count),
    .ebusDriving (ebusDriving),
    .ebusData    (ebusData)
  );

endmodule

`default_nettype wire

// ==== rtl/clkConfigRegs.sv ====
// ####################################################################
// Clock board configuration registers, written by load functions
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module clkConfigRegs (
  input  logic                   CLK,
  input  logic                   reset,
  input  clkDiagPkg::ldPulse_t   ldPulse,
  input  clkDiagPkg::loadData_u  loadData,
  output clkCtlPkg::clkConfig_t  cfg
);

  always_ff @(posedge CLK) begin
    if (reset) begin
      cfg <= '0;
    end else begin
      // Source and rate select, stored for readback only
      if (ldPulse.sourceRate) begin
        cfg.sourceSel <= loadData.sourceRate.sourceSel;
        cfg.rateSel   <= loadData.sourceRate.rateSel;
      end
      // EBOX section disables, top bit unused
      if (ldPulse.eboxDis) begin
        cfg.crmDis <= loadData.eboxDis.crmDis;
        cfg.edpDis <= loadData.eboxDis.edpDis;
        cfg.ctlDis <= loadData.eboxDis.ctlDis;
      end
      // Parity check enables
      if (ldPulse.parCheck) begin
        cfg.fmCheck   <= loadData.parCheck.fm;
        cfg.cramCheck <= loadData.parCheck.cram;
        cfg.dramCheck <= loadData.parCheck.dram;
        cfg.fsCheck   <= loadData.parCheck.fs;
      end
      // Misc enables, incl. error stop enable
      if (ldPulse.misc) begin
        cfg.mboxCycleDis <= loadData.misc.mboxCycleDis;
        cfg.respSim      <= loadData.misc.respSim;
        cfg.arParCheck   <= loadData.misc.arParCheck;
        cfg.errStopEn    <= loadData.misc.errStopEn;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/clkCtlPkg.sv ====
// ####################################################################
// Clock board control types: configuration, run state, parity
// inputs, error flags and EBOX section clock enables
// ####################################################################
`default_nettype none

package clkCtlPkg;

  // Burst counter width, two diagnostic nibbles
  localparam int BURST_W = 8;

  // All load-function configuration bits in one word
  typedef struct packed {
    logic [1:0] sourceSel;
    logic [1:0] rateSel;
    logic       crmDis;
    logic       edpDis;
    logic       ctlDis;
    logic       fmCheck;
    logic       cramCheck;
    logic       dramCheck;
    logic       fsCheck;
    logic       mboxCycleDis;
    logic       respSim;
    logic       arParCheck;
    logic       errStopEn;
  } clkConfig_t;

  typedef struct packed {
    logic go;
    logic burst;
    logic eboxSs;
    logic mrReset;
  } runState_t;

  // Parity good indications from DRAM, CRAM and fast memory
  typedef struct packed {
    logic dramParOk;
    logic cramParOk;
    logic fmParOk;
  } parityIn_t;

  typedef struct packed {
    logic dramErr;
    logic cramErr;
    logic fmErr;
    logic errorStop;
  } errFlags_t;

  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } eboxClkEn_t;

endpackage

`default_nettype wire

// ==== rtl/clkDiagPkg.sv ====
// ####################################################################
// Diagnostic port types for the clock board: bus word, function
// codes, load-data views, decoded pulses and the read word
// ####################################################################
`default_nettype none

package clkDiagPkg;

  // Function select field of the diagnostic bus
  typedef logic [2:0] diagSel_t;

  // Control function codes
  localparam diagSel_t FUNC_START       = 3'd1;
  localparam diagSel_t FUNC_SINGLE_STEP = 3'd2;
  localparam diagSel_t FUNC_EBOX_SS     = 3'd3;
  localparam diagSel_t FUNC_COND_SS     = 3'd4;
  localparam diagSel_t FUNC_BURST       = 3'd5;
  localparam diagSel_t FUNC_CLR_RESET   = 3'd6;
  localparam diagSel_t FUNC_SET_RESET   = 3'd7;

  // Load function codes, 0 and 1 unused
  localparam diagSel_t LD_BURST_LO    = 3'd2;
  localparam diagSel_t LD_BURST_HI    = 3'd3;
  localparam diagSel_t LD_SOURCE_RATE = 3'd4;
  localparam diagSel_t LD_EBOX_DIS    = 3'd5;
  localparam diagSel_t LD_PAR_CHECK   = 3'd6;
  localparam diagSel_t LD_MISC        = 3'd7;

  typedef struct packed {
    logic     ctlFunc;
    logic     ldFunc;
    logic     diagRead;
    diagSel_t select;
    logic [3:0] data;
  } diagBus_t;

  // One data nibble, seen by each load function in its own way
  typedef union packed {
    logic [3:0] nibble;
    struct packed {
      logic [1:0] sourceSel;
      logic [1:0] rateSel;
    } sourceRate;
    struct packed {
      logic spare;
      logic crmDis;
      logic edpDis;
      logic ctlDis;
    } eboxDis;
    struct packed {
      logic fm;
      logic cram;
      logic dram;
      logic fs;
    } parCheck;
    struct packed {
      logic mboxCycleDis;
      logic respSim;
      logic arParCheck;
      logic errStopEn;
    } misc;
  } loadData_u;

  typedef struct packed {
    logic burstLo;
    logic burstHi;
    logic sourceRate;
    logic eboxDis;
    logic parCheck;
    logic misc;
  } ldPulse_t;

  typedef struct packed {
    logic start;
    logic singleStep;
    logic eboxSs;
    logic condSs;
    logic burst;
    logic clrReset;
    logic setReset;
  } ctlPulse_t;

  typedef logic [5:0] readWord_t;

endpackage

`default_nettype wire

// ==== rtl/diagFuncDecoder.sv ====
// ####################################################################
// Diagnostic function decoder, strobes plus select to one-hot pulses
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module diagFuncDecoder (
  input  clkDiagPkg::diagBus_t  diagBus,
  output clkDiagPkg::ctlPulse_t ctlPulse,
  output clkDiagPkg::ldPulse_t  ldPulse
);
  import clkDiagPkg::*;

  // Control function decoder, select 0 is a no-op
  always_comb begin
    ctlPulse = '0;
    if (diagBus.ctlFunc) begin
      case (diagBus.select)
        FUNC_START:       ctlPulse.start      = 1'b1;
        FUNC_SINGLE_STEP: ctlPulse.singleStep = 1'b1;
        FUNC_EBOX_SS:     ctlPulse.eboxSs     = 1'b1;
        FUNC_COND_SS:     ctlPulse.condSs     = 1'b1;
        FUNC_BURST:       ctlPulse.burst      = 1'b1;
        FUNC_CLR_RESET:   ctlPulse.clrReset   = 1'b1;
        FUNC_SET_RESET:   ctlPulse.setReset   = 1'b1;
        default:          ctlPulse            = '0;
      endcase
    end
  end

  // Load function decoder
  // Selects 0 and 1 have no register behind them
  always_comb begin
    ldPulse = '0;
    if (diagBus.ldFunc) begin
      case (diagBus.select)
        LD_BURST_LO:    ldPulse.burstLo    = 1'b1;
        LD_BURST_HI:    ldPulse.burstHi    = 1'b1;
        LD_SOURCE_RATE: ldPulse.sourceRate = 1'b1;
        LD_EBOX_DIS:    ldPulse.eboxDis    = 1'b1;
        LD_PAR_CHECK:   ldPulse.parCheck   = 1'b1;
        LD_MISC:        ldPulse.misc       = 1'b1;
        default:        ldPulse            = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/diagReadback.sv ====
// ####################################################################
// Diagnostic readback mux onto the 6-bit EBUS read word
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module diagReadback (
  input  clkDiagPkg::diagBus_t           diagBus,
  input  clkCtlPkg::clkConfig_t          cfg,
  input  clkCtlPkg::runState_t           runState,
  input  clkCtlPkg::errFlags_t           errFlags,
  input  logic [clkCtlPkg::BURST_W-1:0]  count,
  output logic                           ebusDriving,
  output clkDiagPkg::readWord_t          ebusData
);

  // Bus is only driven during a read strobe
  assign ebusDriving = diagBus.diagRead;

  always_comb begin
    ebusData = '0;
    if (diagBus.diagRead) begin
      case (diagBus.select)
        // Counter high nibble and run bits
        3'd0: ebusData = {count[7:4], runState.go, runState.burst};
        3'd1: ebusData = {count[3:0], runState.eboxSs, runState.mrReset};
        3'd2: ebusData = {cfg.sourceSel, cfg.rateSel, cfg.errStopEn, cfg.mboxCycleDis};
        3'd3: ebusData = {cfg.fmCheck, cfg.cramCheck, cfg.dramCheck, cfg.fsCheck,
                          cfg.crmDis, cfg.edpDis};
        // Error flags
        3'd4: ebusData = {errFlags.dramErr, errFlags.cramErr, errFlags.fmErr,
                          errFlags.errorStop, cfg.ctlDis, cfg.respSim};
        3'd7: ebusData = {cfg.arParCheck, 5'b0};
        // 5 and 6 read as zero
        default: ebusData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/errorCapture.sv ====
// ####################################################################
// Parity error capture, sticky flags and error stop
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module errorCapture (
  input  logic                   CLK,
  input  logic                   reset,
  input  clkCtlPkg::parityIn_t   parity,
  input  clkCtlPkg::clkConfig_t  cfg,
  input  logic                   clrErr,
  output clkCtlPkg::errFlags_t   errFlags
);

  logic dramErr;
  logic cramErr;
  logic fmErr;

  always_ff @(posedge CLK) begin
    if (reset) begin
      dramErr <= 1'b0;
      cramErr <= 1'b0;
      fmErr   <= 1'b0;
    end else if (clrErr) begin
      // Clear reset wipes all errors
      dramErr <= 1'b0;
      cramErr <= 1'b0;
      fmErr   <= 1'b0;
    end else begin
      // Flags hold until cleared
      dramErr <= dramErr || (cfg.dramCheck && !parity.dramParOk);
      cramErr <= cramErr || (cfg.cramCheck && !parity.cramParOk);
      fmErr   <= fmErr   || (cfg.fmCheck   && !parity.fmParOk);
    end
  end

  assign errFlags.dramErr = dramErr;
  assign errFlags.cramErr = cramErr;
  assign errFlags.fmErr   = fmErr;
  // Stop only when enabled
  assign errFlags.errorStop = (dramErr || cramErr || fmErr) && cfg.errStopEn;

endmodule

`default_nettype wire

// ==== rtl/runControl.sv ====
// ####################################################################
// Run control for go, burst and single-step state, the master reset
// flop and the registered EBOX section clock enables
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module runControl (
  input  logic                   CLK,
  input  logic                   reset,
  input  clkDiagPkg::ctlPulse_t  ctlPulse,
  input  clkCtlPkg::clkConfig_t  cfg,
  input  logic                   countZero,
  input  logic                   errorStop,
  output clkCtlPkg::runState_t   runState,
  output clkCtlPkg::eboxClkEn_t  eboxClkEn
);

  logic stepReq;
  logic anyCtl;
  logic rawEn;

  // Any control function reloads the run state
  assign anyCtl = |ctlPulse;

  // Raw enable for the section clocks
  // Burst is not held off by the error stop
  assign rawEn = ((runState.go || runState.eboxSs || stepReq) && !errorStop) ||
                 (runState.burst && !countZero);

  always_ff @(posedge CLK) begin
    if (reset) begin
      runState.go      <= 1'b0;
      runState.burst   <= 1'b0;
      runState.eboxSs  <= 1'b0;
      runState.mrReset <= 1'b1;
      stepReq          <= 1'b0;
    end else begin
      // Single step request lasts one cycle
      stepReq <= ctlPulse.singleStep || ctlPulse.condSs;
      if (anyCtl) begin
        runState.go     <= ctlPulse.start;
        runState.burst  <= ctlPulse.burst;
        runState.eboxSs <= ctlPulse.eboxSs;
      end else begin
        // EBOX single step gives one cycle then drops
        runState.eboxSs <= 1'b0;
        // Burst ends once the counter has run out
        if (runState.burst && countZero) begin
          runState.burst <= 1'b0;
        end
      end
      // Master reset flop is set by clear reset and cleared by set reset
      if (ctlPulse.clrReset) begin
        runState.mrReset <= 1'b1;
      end else if (ctlPulse.setReset) begin
        runState.mrReset <= 1'b0;
      end
    end
  end

  // Section enables lag the run state by one cycle
  always_ff @(posedge CLK) begin
    if (reset) begin
      eboxClkEn <= '0;
    end else begin
      eboxClkEn.crm <= rawEn && !cfg.crmDis;
      eboxClkEn.edp <= rawEn && !cfg.edpDis;
      eboxClkEn.ctl <= rawEn && !cfg.ctlDis;
    end
  end

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module tbClkBoard -f vlog.f
./obj_dir/VtbClkBoard | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// ==== test/tbClkTests.svh ====
// ####################################################################
// Directed clock board tests driven over the diagnostic bus
// ####################################################################
`ifndef TB_CLK_TESTS_SVH
`define TB_CLK_TESTS_SVH

  // Drive a one-cycle strobe and return the bus to idle
  task automatic pulseBus(input diagBus_t bus);
    @(posedge CLK);
    diagBus <= bus;
    @(posedge CLK);
    diagBus <= '0;
  endtask

  task automatic ctlFunction(input diagSel_t sel);
    diagBus_t bus;
    bus         = '0;
    bus.ctlFunc = 1'b1;
    bus.select  = sel;
    pulseBus(bus);
  endtask

  task automatic loadFunction(input diagSel_t sel, input logic [3:0] nibble);
    diagBus_t bus;
    bus        = '0;
    bus.ldFunc = 1'b1;
    bus.select = sel;
    bus.data   = nibble;
    pulseBus(bus);
  endtask

  // Read data is combinational and sampled mid-cycle
  task automatic readWord(input diagSel_t sel, output readWord_t word);
    diagBus_t bus;
    bus          = '0;
    bus.diagRead = 1'b1;
    bus.select   = sel;
    @(posedge CLK);
    diagBus <= bus;
    @(negedge CLK);
    compareValue("ebusDriving during read", 32'(ebusDriving), 32'd1);
    word = ebusData;
    @(posedge CLK);
    diagBus <= '0;
  endtask

  task automatic waitForEnable(input eboxClkEn_t expected, input string what);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (eboxClkEn !== expected) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abortOnTimeout(what);
      end
      @(negedge CLK);
    end
  endtask

  // Enabled cycles of one run with all sections on
  task automatic countEnabledCycles(output int total);
    eboxClkEn_t allOn;
    allOn = '1;
    waitForEnable(allOn, "section enables to rise");
    total = 0;
    while (eboxClkEn == allOn) begin
      total++;
      if (total > BURST_LIMIT) begin
        abortOnTimeout("section enables to fall");
      end
      @(negedge CLK);
    end
    compareValue("enables after run", 32'(eboxClkEn), 32'd0);
  endtask

  task automatic resetBehavior();
    readWord_t word;
    @(negedge CLK);
    compareValue("mrReset after reset", 32'(mrReset), 32'd1);
    compareValue("enables after reset", 32'(eboxClkEn), 32'd0);
    // Count zero, eboxSs low, mrReset high
    readWord(3'd1, word);
    compareValue("select 1 after reset", 32'(word), 32'h01);
    ctlFunction(FUNC_SET_RESET);
    @(negedge CLK);
    compareValue("mrReset after set reset", 32'(mrReset), 32'd0);
    ctlFunction(FUNC_CLR_RESET);
    @(negedge CLK);
    compareValue("mrReset after clear reset", 32'(mrReset), 32'd1);
  endtask

  task automatic configRoundTrip();
    logic [31:0] rnd;
    logic [3:0]  srcRate;
    logic [3:0]  dis;
    logic [3:0]  parChk;
    logic [3:0]  misc;
    readWord_t   word;
    for (int round = 0; round < 3; round++) begin
      rnd     = nextRandom();
      srcRate = rnd[3:0];
      dis     = rnd[7:4];
      parChk  = rnd[11:8];
      misc    = rnd[15:12];
      loadFunction(LD_SOURCE_RATE, srcRate);
      loadFunction(LD_EBOX_DIS, dis);
      loadFunction(LD_PAR_CHECK, parChk);
      loadFunction(LD_MISC, misc);
      // Source, rate, errStopEn, mboxCycleDis
      readWord(3'd2, word);
      compareValue("select 2 read", 32'(word), 32'({srcRate, misc[0], misc[3]}));
      // Check enables, crmDis, edpDis
      readWord(3'd3, word);
      compareValue("select 3 read", 32'(word), 32'({parChk, dis[2], dis[1]}));
      // No errors with good parity
      readWord(3'd4, word);
      compareValue("select 4 read", 32'(word), 32'({4'b0000, dis[0], misc[2]}));
      readWord(3'd7, word);
      compareValue("select 7 read", 32'(word), 32'({misc[1], 5'b00000}));
      @(negedge CLK);
      compareValue("ebusDriving when idle", 32'(ebusDriving), 32'd0);
      compareValue("ebusData when idle", 32'(ebusData), 32'd0);
    end
  endtask

  task automatic burstLength();
    logic [31:0] rnd;
    logic [7:0]  burstLen;
    int          total;
    readWord_t   word;
    loadFunction(LD_EBOX_DIS, 4'h0);
    rnd      = nextRandom();
    burstLen = rnd[7:0];
    // A zero count would give no enables to wait for
    if (burstLen == 8'd0) begin
      burstLen = 8'd1;
    end
    loadFunction(LD_BURST_LO, burstLen[3:0]);
    loadFunction(LD_BURST_HI, burstLen[7:4]);
    readWord(3'd0, word);
    compareValue("select 0 before burst", 32'(word), 32'({burstLen[7:4], 2'b00}));
    readWord(3'd1, word);
    compareValue("select 1 before burst", 32'(word), 32'({burstLen[3:0], 2'b01}));
    ctlFunction(FUNC_BURST);
    countEnabledCycles(total);
    compareValue("burst enabled cycles", 32'(total), 32'(burstLen));
    // Count zero and burst clear
    readWord(3'd0, word);
    compareValue("select 0 after burst", 32'(word), 32'd0);
  endtask

  task automatic startStopStep();
    int total;
    ctlFunction(FUNC_START);
    waitForEnable(3'b111, "enables after start");
    repeat (5) begin
      @(negedge CLK);
      compareValue("enables during run", 32'(eboxClkEn), 32'h7);
    end
    ctlFunction(FUNC_SET_RESET);
    waitForEnable(3'b000, "enables to drop after set reset");
    ctlFunction(FUNC_EBOX_SS);
    countEnabledCycles(total);
    compareValue("EBOX single step cycles", 32'(total), 32'd1);
    ctlFunction(FUNC_SINGLE_STEP);
    countEnabledCycles(total);
    compareValue("single step cycles", 32'(total), 32'd1);
  endtask

  task automatic sectionDisables();
    // CRM off, EDP and CTL on
    loadFunction(LD_EBOX_DIS, 4'b0100);
    ctlFunction(FUNC_START);
    waitForEnable(3'b011, "edp and ctl enables after start");
    repeat (4) begin
      @(negedge CLK);
      compareValue("enables with crm disabled", 32'(eboxClkEn), 32'h3);
    end
    ctlFunction(FUNC_SET_RESET);
    waitForEnable(3'b000, "enables to drop after set reset");
    loadFunction(LD_EBOX_DIS, 4'h0);
  endtask

  task automatic parityErrorStop();
    readWord_t word;
    // DRAM check and error stop enable only
    loadFunction(LD_PAR_CHECK, 4'b0010);
    loadFunction(LD_MISC, 4'b0001);
    @(posedge CLK);
    parity.dramParOk <= 1'b0;
    @(posedge CLK);
    parity.dramParOk <= 1'b1;
    readWord(3'd4, word);
    compareValue("select 4 after dram error", 32'(word), 32'h24);
    @(negedge CLK);
    compareValue("errorStop after dram error", 32'(errorStop), 32'd1);
    // Error stop holds the run off
    ctlFunction(FUNC_START);
    repeat (4) begin
      @(negedge CLK);
      compareValue("enables under error stop", 32'(eboxClkEn), 32'd0);
    end
    ctlFunction(FUNC_CLR_RESET);
    readWord(3'd4, word);
    compareValue("select 4 after clear reset", 32'(word), 32'd0);
    @(negedge CLK);
    compareValue("errorStop after clear reset", 32'(errorStop), 32'd0);
    loadFunction(LD_PAR_CHECK, 4'h0);
    loadFunction(LD_MISC, 4'h0);
  endtask

`endif

// ==== test/tbClkBoard.sv ====
// ####################################################################
// Testbench for the clock board diagnostic control
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module tbClkBoard;
  import clkDiagPkg::*;
  import clkCtlPkg::*;

  // Wait limits in clock cycles
  localparam int WAIT_LIMIT  = 20;
  localparam int BURST_LIMIT = 300;

  logic       CLK;
  logic       reset;
  diagBus_t   diagBus;
  parityIn_t  parity;
  eboxClkEn_t eboxClkEn;
  logic       mrReset;
  logic       errorStop;
  logic       ebusDriving;
  readWord_t  ebusData;

  // Check bookkeeping and random state
  int          errorCount;
  int          checkCount;
  logic [31:0] rngState;

  clkBoard i_clkBoard (
    .CLK         (CLK),
    .reset       (reset),
    .diagBus     (diagBus),
    .parity      (parity),
    .eboxClkEn   (eboxClkEn),
    .mrReset     (mrReset),
    .errorStop   (errorStop),
    .ebusDriving (ebusDriving),
    .ebusData    (ebusData)
  );

  // 8 ns clock
  always #4 CLK = ~CLK;

  task automatic compareValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, actual,
               expected);
    end
  endtask

  // Xorshift32 step
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  task automatic printSummary();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
  endtask

  // A wait ran out of cycles, end the run here
  task automatic abortOnTimeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    printSummary();
    $display("Test failures found");
    $finish;
  endtask

  `include "tbClkTests.svh"

  initial begin
    CLK        = 1'b0;
    reset      = 1'b1;
    diagBus    = '0;
    parity     = '1;
    errorCount = 0;
    checkCount = 0;
    rngState   = 32'hfd0b;
    // Hold reset over four rising edges
    repeat (4) @(posedge CLK);
    reset <= 1'b0;

    resetBehavior();
    configRoundTrip();
    burstLength();
    startStopStep();
    sectionDisables();
    parityErrorStop();

    printSummary();
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+test
rtl/clkDiagPkg.sv
rtl/clkCtlPkg.sv
rtl/diagFuncDecoder.sv
rtl/clkConfigRegs.sv
rtl/burstCounter.sv
rtl/runControl.sv
rtl/errorCapture.sv
rtl/diagReadback.sv
rtl/clkBoard.sv
test/tbClkBoard.sv
